/* compile.f */
+incdir+logic
logic/mr_pkg.sv
logic/mr_status_decode.sv
logic/mr_crop_ctrl.sv
logic/mr_mouse_decode.sv
logic/mr_user_port.sv
logic/mr_glue_top.sv
test/tb_mr_glue.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_mr_glue
FILELIST  = compile.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)

SOURCES   = $(shell grep -v '^+' $(FILELIST)) logic/mr_consts.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_mr_glue.sv */
/*
    Testbench for the MiSTer wrapper glue
    Random OSD settings, video modes, mouse packets and user-port traffic,
    each checked against a reference model of the decode rules
*/
`include "mr_consts.svh"

module tb_mr_glue;
    timeunit 1ns;
    timeprecision 1ps;

    import mr_pkg::*;

    localparam int TRIALS     = 400;
    localparam int MAX_CYCLES = 5000;

    logic         clk_sys;
    logic         rst;
    status_t      status;
    logic         core_mod0;
    logic         direct_video;
    logic         force_scan2x;
    logic         rotate0;
    hdmi_dim_t    hdmi_width;
    hdmi_dim_t    hdmi_height;
    mouse_pkt_t   ps2_mouse;
    user_port_t   user_in;
    user_port_t   joy_out;
    logic         core_tx;
    logic         cheat_tx;
    logic         crop_en;
    vcopt_t       vcopt;
    crop_scale_t  crop_scale;
    offset_t      hoffset;
    offset_t      voffset;
    logic         hsize_enable;
    hsize_scale_t hsize_scale;
    logic         db15_en;
    logic         uart_en;
    logic         framebuf_flip;
    menumask_t    menumask;
    logic         crop_ok;
    crop_off_t    crop_off;
    crop_size_t   crop_size;
    logic         mouse_st;
    mouse_delta_t mouse_dx;
    mouse_delta_t mouse_dy;
    logic [7:0]   mouse_f;
    user_port_t   user_out;
    logic         game_rx;

    // RX pin one and two cycles back, for the synchronizer delay
    logic pin_d1;
    logic pin_d2;
    int   cycles = 0;

    mr_glue_top UUT (.*);

    always #50 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            stop_run($sformatf("Timeout: run exceeded %0d clock cycles", MAX_CYCLES));
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input string exp, input string act);
        stop_run($sformatf("ERR %s expected %s actual %s", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_offset(input string name, input offset_t exp, input offset_t act);
        if (exp !== act) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_hsize(input string name, input hsize_scale_t exp,
                               input hsize_scale_t act);
        if (exp !== act) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_vcopt(input string name, input vcopt_t exp, input vcopt_t act);
        if (exp !== act) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_scale(input string name, input crop_scale_t exp,
                               input crop_scale_t act);
        if (exp !== act) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_mask(input string name, input menumask_t exp, input menumask_t act);
        if (exp !== act) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_size(input string name, input crop_size_t exp, input crop_size_t act);
        if (exp !== act) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_off(input string name, input crop_off_t exp, input crop_off_t act);
        if (exp !== act) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_delta(input string name, input mouse_delta_t exp,
                               input mouse_delta_t act);
        if (exp !== act) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_flags(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_port(input string name, input user_port_t exp, input user_port_t act);
        if (exp !== act) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    // Step to the drive point just after a rising edge
    task automatic tick();
        @(posedge clk_sys);
        #5;
        pin_d2 = pin_d1;
        pin_d1 = user_in[1];
    endtask

    task automatic settings_trial();
        logic       ok;
        int         vc;
        int         off;
        menumask_t  mask;
        user_port_t port;
        status = {$urandom, $urandom};
        if ($urandom % 2 == 0) begin
            hdmi_width  = hdmi_dim_t'(`MR_CROP_HDMI_W);
            hdmi_height = hdmi_dim_t'(`MR_CROP_HDMI_H);
            // Clear effect and scaler often so crop is reachable
            if ($urandom % 2 == 0) begin
                status[`MR_ST_FX_LO +: 3]    = '0;
                status[`MR_ST_SCALE_LO +: 2] = '0;
            end
        end else begin
            hdmi_width  = hdmi_dim_t'($urandom);
            hdmi_height = hdmi_dim_t'($urandom);
        end
        force_scan2x = ($urandom % 4) == 0;
        direct_video = ($urandom % 4) == 0;
        rotate0      = ($urandom % 4) == 0;
        core_mod0    = 1'($urandom);
        joy_out      = user_port_t'($urandom);
        core_tx      = 1'($urandom);
        cheat_tx     = ($urandom % 4) != 0;
        repeat (6) begin
            tick();
            user_in = user_port_t'($urandom);
        end

        // Reference model
        ok = hdmi_width == hdmi_dim_t'(`MR_CROP_HDMI_W) &&
             hdmi_height == hdmi_dim_t'(`MR_CROP_HDMI_H) &&
             status[`MR_ST_FX_LO +: 3] == 3'd0 && !force_scan2x &&
             status[`MR_ST_SCALE_LO +: 2] == 2'd0 && !direct_video && !rotate0;
        vc  = int'(status[`MR_ST_VCOPT_LO +: 4]);
        off = (vc < `MR_VCOPT_WRAP) ? 2 * vc : 2 * vc - `MR_VCOPT_BIAS;
        mask    = '0;
        mask[5] = ok;
        mask[4] = 1'b1;
        mask[3] = 1'b1;
        mask[2] = ~status[`MR_ST_HSIZE_EN];
        mask[1] = ~core_mod0;
        mask[0] = direct_video;
        if (status[`MR_ST_DB15])
            port = joy_out;
        else if (status[`MR_ST_UART])
            port = {6'h3f, core_tx & cheat_tx};
        else
            port = '1;

        check_offset("hoffset", status[`MR_ST_OFFSET_LO +: 4], hoffset);
        check_offset("voffset", status[`MR_ST_OFFSET_LO + 4 +: 4], voffset);
        check_bit("hsize_enable", status[`MR_ST_HSIZE_EN], hsize_enable);
        check_hsize("hsize_scale", status[`MR_ST_HSIZE_LO +: 4], hsize_scale);
        check_bit("framebuf_flip", status[39:38] == 2'd2, framebuf_flip);
        check_bit("db15_en", status[`MR_ST_DB15], db15_en);
        check_bit("uart_en", status[`MR_ST_UART], uart_en);
        check_bit("crop_en", status[`MR_ST_CROP_EN], crop_en);
        check_vcopt("vcopt", status[`MR_ST_VCOPT_LO +: 4], vcopt);
        check_scale("crop_scale", {1'b0, status[`MR_ST_SCALE_LO +: 2]}, crop_scale);
        check_bit("crop_ok", ok, crop_ok);
        check_off("crop_off", crop_off_t'(off), crop_off);
        check_size("crop_size", (ok && status[`MR_ST_CROP_EN]) ?
                   crop_size_t'(`MR_CROP_LINES) : '0, crop_size);
        check_mask("menumask", mask, menumask);
        check_port("user_out", port, user_out);
        check_bit("game_rx", status[`MR_ST_UART] ? pin_d2 : 1'b1, game_rx);
    endtask

    task automatic mouse_packet();
        mouse_pkt_t pkt;
        logic       flip;
        flip       = ($urandom % 4) != 0;
        pkt.toggle = ps2_mouse.toggle ^ flip;
        pkt.dy     = 8'($urandom);
        pkt.dx     = 8'($urandom);
        pkt.flags  = 8'($urandom);
        ps2_mouse  = pkt;
        tick();
        if (flip && mouse_st !== 1'b1)
            stop_run("mouse_st did not pulse after a toggle flip");
        if (!flip && mouse_st !== 1'b0)
            stop_run("mouse_st pulsed although the toggle kept its value");
        if (flip) begin
            check_delta("mouse_dx", {pkt.flags[4], pkt.dx}, mouse_dx);
            check_delta("mouse_dy", {pkt.flags[5], pkt.dy}, mouse_dy);
            check_flags("mouse_f", pkt.flags, mouse_f);
        end
        tick();
        if (mouse_st !== 1'b0)
            stop_run("mouse_st stayed high for more than one cycle");
    endtask

    initial begin
        void'($urandom(32'h300));
        clk_sys      = 1'b0;
        rst          = 1'b1;
        status       = '0;
        core_mod0    = 1'b0;
        direct_video = 1'b0;
        force_scan2x = 1'b0;
        rotate0      = 1'b0;
        hdmi_width   = '0;
        hdmi_height  = '0;
        ps2_mouse    = '0;
        user_in      = '1;
        joy_out      = '1;
        core_tx      = 1'b1;
        cheat_tx     = 1'b1;
        pin_d1       = 1'b1;
        pin_d2       = 1'b1;
        tick();
        tick();

        // Values held in reset
        check_bit("reset mouse_st", 1'b0, mouse_st);
        check_port("reset user_out", '1, user_out);
        check_bit("reset game_rx", 1'b1, game_rx);
        check_size("reset crop_size", '0, crop_size);
        check_bit("reset crop_ok", 1'b0, crop_ok);
        check_mask("reset menumask", '0, menumask);
        rst = 1'b0;

        for (int t = 0; t < TRIALS; t++) begin
            settings_trial();
            if (t % 2 == 1)
                mouse_packet();
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* logic/mr_glue_top.sv */
/*
    MiSTer wrapper glue top level
    Status decode, 1080p crop control, mouse decode and user port
*/
module mr_glue_top (
    input  logic                 clk_sys,
    input  logic                 rst,
    // OSD and video mode
    input  mr_pkg::status_t      status,
    input  logic                 core_mod0,
    input  logic                 direct_video,
    input  logic                 force_scan2x,
    input  logic                 rotate0,
    input  mr_pkg::hdmi_dim_t    hdmi_width,
    input  mr_pkg::hdmi_dim_t    hdmi_height,
    // HPS mouse
    input  mr_pkg::mouse_pkt_t   ps2_mouse,
    // User port
    input  mr_pkg::user_port_t   user_in,
    input  mr_pkg::user_port_t   joy_out,
    input  logic                 core_tx,
    input  logic                 cheat_tx,
    // Decoded settings
    output logic                 crop_en,
    output mr_pkg::vcopt_t       vcopt,
    output mr_pkg::crop_scale_t  crop_scale,
    output mr_pkg::offset_t      hoffset,
    output mr_pkg::offset_t      voffset,
    output logic                 hsize_enable,
    output mr_pkg::hsize_scale_t hsize_scale,
    output logic                 db15_en,
    output logic                 uart_en,
    output logic                 framebuf_flip,
    output mr_pkg::menumask_t    menumask,
    // Crop
    output logic                 crop_ok,
    output mr_pkg::crop_off_t    crop_off,
    output mr_pkg::crop_size_t   crop_size,
    // Mouse event
    output logic                 mouse_st,
    output mr_pkg::mouse_delta_t mouse_dx,
    output mr_pkg::mouse_delta_t mouse_dy,
    output logic [7:0]           mouse_f,
    // User port
    output mr_pkg::user_port_t   user_out,
    output logic                 game_rx
);

    logic fx_off;
    logic uart_tx;

    // Core and cheat UARTs share one line
    assign uart_tx = core_tx & cheat_tx;

    mr_status_decode u_status (
        .clk_sys       ( clk_sys       ),
        .rst           ( rst           ),
        .status        ( status        ),
        .core_mod0     ( core_mod0     ),
        .direct_video  ( direct_video  ),
        .crop_ok       ( crop_ok       ),
        .crop_en       ( crop_en       ),
        .vcopt         ( vcopt         ),
        .crop_scale    ( crop_scale    ),
        .fx_off        ( fx_off        ),
        .hoffset       ( hoffset       ),
        .voffset       ( voffset       ),
        .hsize_enable  ( hsize_enable  ),
        .hsize_scale   ( hsize_scale   ),
        .db15_en       ( db15_en       ),
        .uart_en       ( uart_en       ),
        .framebuf_flip ( framebuf_flip ),
        .menumask      ( menumask      )
    );

    mr_crop_ctrl u_crop (
        .clk_sys       ( clk_sys       ),
        .rst           ( rst           ),
        .hdmi_width    ( hdmi_width    ),
        .hdmi_height   ( hdmi_height   ),
        .fx_off        ( fx_off        ),
        .force_scan2x  ( force_scan2x  ),
        .direct_video  ( direct_video  ),
        .rotate0       ( rotate0       ),
        .crop_en       ( crop_en       ),
        .crop_scale    ( crop_scale    ),
        .vcopt         ( vcopt         ),
        .crop_ok       ( crop_ok       ),
        .crop_off      ( crop_off      ),
        .crop_size     ( crop_size     )
    );

    mr_mouse_decode u_mouse (
        .clk_sys       ( clk_sys       ),
        .rst           ( rst           ),
        .ps2_mouse     ( ps2_mouse     ),
        .mouse_st      ( mouse_st      ),
        .mouse_dx      ( mouse_dx      ),
        .mouse_dy      ( mouse_dy      ),
        .mouse_f       ( mouse_f       )
    );

    mr_user_port u_user (
        .clk_sys       ( clk_sys       ),
        .rst           ( rst           ),
        .user_in       ( user_in       ),
        .joy_out       ( joy_out       ),
        .db15_en       ( db15_en       ),
        .uart_en       ( uart_en       ),
        .uart_tx       ( uart_tx       ),
        .user_out      ( user_out      ),
        .uart_rx       ( game_rx       )
    );

endmodule

/* logic/mr_user_port.sv */
/*
    User port multiplexer
    Shares the 7 pins between the DB15 joystick adapter and a UART
*/
module mr_user_port (
    input  logic               clk_sys,
    input  logic               rst,
    input  mr_pkg::user_port_t user_in,
    input  mr_pkg::user_port_t joy_out,
    input  logic               db15_en,
    input  logic               uart_en,
    input  logic               uart_tx,
    output mr_pkg::user_port_t user_out,
    output logic               uart_rx
);
    import mr_pkg::*;

    user_port_t out_next;
    logic [1:0] rx_sync;

    // Joystick adapter wins, idle pins float high
    always_comb begin
        if (db15_en) begin
            out_next = joy_out;
        end else if (uart_en) begin
            out_next = {6'h3f, uart_tx};
        end else begin
            out_next = '1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            user_out <= '1;
            rx_sync  <= 2'b11;
        end else begin
            user_out <= out_next;
            rx_sync  <= {rx_sync[0], user_in[1]};
        end
    end

    assign uart_rx = uart_en ? rx_sync[1] : 1'b1;

endmodule

/* logic/mr_mouse_decode.sv */
/*
    HPS mouse packet decoder
    Turns each flip of the packet toggle into a one-cycle strobe
    with signed deltas and the button flags
*/
module mr_mouse_decode (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  mr_pkg::mouse_pkt_t   ps2_mouse,
    output logic                 mouse_st,
    output mr_pkg::mouse_delta_t mouse_dx,
    output mr_pkg::mouse_delta_t mouse_dy,
    output logic [7:0]           mouse_f
);

    logic toggle_l;
    logic new_pkt;

    assign new_pkt = ps2_mouse.toggle ^ toggle_l;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            // Track the current toggle so reset release gives no event
            toggle_l <= ps2_mouse.toggle;
            mouse_st <= 1'b0;
        end else begin
            toggle_l <= ps2_mouse.toggle;
            mouse_st <= new_pkt;
        end
    end

    // Sign bits travel in the flags byte
    always_ff @(posedge clk_sys) begin
        if (new_pkt) begin
            mouse_f  <= ps2_mouse.flags;
            mouse_dx <= {ps2_mouse.flags[4], ps2_mouse.dx};
            mouse_dy <= {ps2_mouse.flags[5], ps2_mouse.dy};
        end
    end

endmodule

/* logic/mr_crop_ctrl.sv */
/*
    Vertical crop control for 1080p HDMI
    Decides whether cropping is allowed and sets the crop offset and size
*/
`include "mr_consts.svh"

module mr_crop_ctrl (
    input  logic                clk_sys,
    input  logic                rst,
    input  mr_pkg::hdmi_dim_t   hdmi_width,
    input  mr_pkg::hdmi_dim_t   hdmi_height,
    input  logic                fx_off,
    input  logic                force_scan2x,
    input  logic                direct_video,
    input  logic                rotate0,
    input  logic                crop_en,
    input  mr_pkg::crop_scale_t crop_scale,
    input  mr_pkg::vcopt_t      vcopt,
    output logic                crop_ok,
    output mr_pkg::crop_off_t   crop_off,
    output mr_pkg::crop_size_t  crop_size
);
    import mr_pkg::*;

    logic      full_hd;
    crop_off_t vc_twice;

    assign full_hd  = hdmi_width  == hdmi_dim_t'(`MR_CROP_HDMI_W) &&
                      hdmi_height == hdmi_dim_t'(`MR_CROP_HDMI_H);
    // Two lines per option step
    assign vc_twice = {vcopt, 1'b0};

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            crop_ok   <= 1'b0;
            crop_size <= '0;
        end else begin
            // Any scaler or effect that changes line count rules it out
            crop_ok   <= full_hd && fx_off && !force_scan2x && crop_scale == '0 &&
                         !direct_video && !rotate0;
            crop_size <= (crop_ok && crop_en) ? crop_size_t'(`MR_CROP_LINES) : '0;
        end
    end

    // Upper options wrap round to negative offsets
    always_ff @(posedge clk_sys) begin
        if (vcopt < vcopt_t'(`MR_VCOPT_WRAP)) begin
            crop_off <= vc_twice;
        end else begin
            crop_off <= vc_twice - crop_off_t'(`MR_VCOPT_BIAS);
        end
    end

endmodule

/* logic/mr_status_decode.sv */
/*
    OSD status decoder
    Registers the named settings out of the 64-bit status word
    and builds the menu visibility mask
*/
`include "mr_consts.svh"

module mr_status_decode (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  mr_pkg::status_t      status,
    input  logic                 core_mod0,
    input  logic                 direct_video,
    input  logic                 crop_ok,
    output logic                 crop_en,
    output mr_pkg::vcopt_t       vcopt,
    output mr_pkg::crop_scale_t  crop_scale,
    output logic                 fx_off,
    output mr_pkg::offset_t      hoffset,
    output mr_pkg::offset_t      voffset,
    output logic                 hsize_enable,
    output mr_pkg::hsize_scale_t hsize_scale,
    output logic                 db15_en,
    output logic                 uart_en,
    output logic                 framebuf_flip,
    output mr_pkg::menumask_t    menumask
);
    import mr_pkg::*;

    menumask_t mask_next;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            crop_en       <= 1'b0;
            vcopt         <= '0;
            crop_scale    <= '0;
            fx_off        <= 1'b0;
            hoffset       <= '0;
            voffset       <= '0;
            hsize_enable  <= 1'b0;
            hsize_scale   <= '0;
            db15_en       <= 1'b0;
            uart_en       <= 1'b0;
            framebuf_flip <= 1'b0;
        end else begin
            crop_en       <= status[`MR_ST_CROP_EN];
            vcopt         <= status[`MR_ST_VCOPT_LO +: `MR_VCOPT_W];
            // Only two scaler bits in the menu
            crop_scale    <= {1'b0, status[`MR_ST_SCALE_LO +: `MR_SCALE_W-1]};
            // No scan-line effect selected
            fx_off        <= status[`MR_ST_FX_LO +: `MR_FX_W] == '0;
            hoffset       <= status[`MR_ST_OFFSET_LO +: `MR_OFFSET_W];
            voffset       <= status[`MR_ST_OFFSET_LO+`MR_OFFSET_W +: `MR_OFFSET_W];
            hsize_enable  <= status[`MR_ST_HSIZE_EN];
            hsize_scale   <= status[`MR_ST_HSIZE_LO +: `MR_HSIZE_W];
            db15_en       <= status[`MR_ST_DB15];
            uart_en       <= status[`MR_ST_UART];
            framebuf_flip <= status[`MR_ST_FLIP_LO +: 2] == 2'd2;
        end
    end

    always_comb begin
        mask_next    = '0;
        // Crop options only shown when the video mode allows it
        mask_next[5] = crop_ok;
        // Rotation and 60 Hz items stay hidden
        mask_next[4] = 1'b1;
        mask_next[3] = 1'b1;
        mask_next[2] = ~hsize_enable;
        // Vertical games get the rotate item
        mask_next[1] = ~core_mod0;
        mask_next[0] = direct_video;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            menumask <= '0;
        end else begin
            menumask <= mask_next;
        end
    end

endmodule

/* logic/mr_pkg.sv */
/*
    MiSTer glue types
    Status word, menu mask, crop settings, mouse packet and user port
*/
`include "mr_consts.svh"

package mr_pkg;

    typedef logic [`MR_STATUS_W-1:0]      status_t;
    // A high bit hides the menu item
    typedef logic [`MR_MENUMASK_W-1:0]    menumask_t;
    typedef logic [`MR_HDMI_DIM_W-1:0]    hdmi_dim_t;

    // Vertical crop controls
    typedef logic [`MR_VCOPT_W-1:0]       vcopt_t;
    typedef logic [`MR_SCALE_W-1:0]       crop_scale_t;
    typedef logic signed [`MR_CROP_OFF_W-1:0] crop_off_t;
    typedef logic [`MR_CROP_SIZE_W-1:0]   crop_size_t;

    // CRT picture position and horizontal scale
    typedef logic [`MR_OFFSET_W-1:0]      offset_t;
    typedef logic [`MR_HSIZE_W-1:0]       hsize_scale_t;

    // HPS mouse packet, toggle flips once per new packet
    typedef struct packed {
        logic       toggle;
        logic [7:0] dy;
        logic [7:0] dx;
        logic [7:0] flags;
    } mouse_pkt_t;

    typedef logic signed [`MR_MOUSE_DELTA_W-1:0] mouse_delta_t;

    typedef logic [`MR_USER_PORT_W-1:0]   user_port_t;

endpackage

/* logic/mr_consts.svh */
/*
    MiSTer glue constants
    OSD status bit positions, field widths and 1080p crop values
*/
`ifndef MR_CONSTS_SVH
`define MR_CONSTS_SVH

// Status word bit positions
`define MR_ST_FX_LO         3
`define MR_ST_DB15          37
`define MR_ST_UART          38
`define MR_ST_FLIP_LO       38
`define MR_ST_CROP_EN       41
`define MR_ST_VCOPT_LO      42
`define MR_ST_SCALE_LO      46
`define MR_ST_HSIZE_EN      48
`define MR_ST_HSIZE_LO      49
`define MR_ST_OFFSET_LO     53

// Field widths
`define MR_STATUS_W         64
`define MR_MENUMASK_W       16
`define MR_HDMI_DIM_W       12
`define MR_FX_W             3
`define MR_VCOPT_W          4
`define MR_SCALE_W          3
`define MR_CROP_OFF_W       5
`define MR_CROP_SIZE_W      12
`define MR_OFFSET_W         4
`define MR_HSIZE_W          4
`define MR_MOUSE_DELTA_W    9
`define MR_USER_PORT_W      7

// Vertical crop for 1080p HDMI
`define MR_CROP_HDMI_W      1920
`define MR_CROP_HDMI_H      1080
`define MR_CROP_LINES       216
`define MR_VCOPT_WRAP       6
`define MR_VCOPT_BIAS       24

`endif
